/* tcb_defs.svh */
// 32-bit bus word only; TCB_BUS_MAX must equal log2(TCB_BUS_BYT) and memory depth must fit the address

`ifndef TCB_DEFS_SVH
`define TCB_DEFS_SVH

//////////////////////////////////////////////////
// bus geometry
//////////////////////////////////////////////////

// byte address width
`define TCB_ADR_WIDTH 16
// bytes per bus word
`define TCB_BUS_BYT 4
// offset bits inside a word
`define TCB_BUS_MAX 2

//////////////////////////////////////////////////
// timing and memory size
//////////////////////////////////////////////////

// response delay after handshake, in cycles
`define TCB_HSK_DLY 1
// implemented words in the memory
`define TCB_MEM_DEPTH 256

`endif

/* tcb_pkg.sv */
// bus types for a 4-lane bus; sizes above 4 bytes and endianness other than little/big are not defined
`default_nettype none

`include "tcb_defs.svh"

package tcb_pkg;

  //////////////////////////////////////////////////
  // data and lane types
  //////////////////////////////////////////////////

  // single byte
  typedef logic [7:0] tcb_byte_t;

  // bus word, byte index equals lane index
  typedef tcb_byte_t [`TCB_BUS_BYT-1:0] tcb_dat_t;

  // one enable per lane
  typedef logic [`TCB_BUS_BYT-1:0] tcb_ben_t;

  // log2 of transfer size
  typedef enum logic [1:0] {
    TCB_SIZ_1 = 2'd0,
    TCB_SIZ_2 = 2'd1,
    TCB_SIZ_4 = 2'd2
  } tcb_siz_t;

  // byte order inside an access
  typedef enum logic {
    TCB_LITTLE = 1'b0,
    TCB_BIG    = 1'b1
  } tcb_ndn_t;

  //////////////////////////////////////////////////
  // request and response
  //////////////////////////////////////////////////

  // siz filled by log-size manager, byt by the converter
  typedef struct packed {
    logic                      wen;
    logic [`TCB_ADR_WIDTH-1:0] adr;
    tcb_siz_t                  siz;
    tcb_ndn_t                  ndn;
    tcb_ben_t                  byt;
    tcb_dat_t                  wdt;
  } tcb_req_t;

  // read data plus error status
  typedef struct packed {
    tcb_dat_t rdt;
    logic     sts;
  } tcb_rsp_t;

endpackage

`default_nettype wire

/* tcb_if.sv */
// fixed response delay of TCB_HSK_DLY cycles after handshake; the manager cannot stall a response
`timescale 1ns/10ps
`default_nettype none

`include "tcb_defs.svh"

interface tcb_if (
  // bus clock
  input logic clk,
  // synchronous reset, active low
  input logic rst_n
);

  import tcb_pkg::*;

  //////////////////////////////////////////////////
  // bus signals
  //////////////////////////////////////////////////

  // handshake
  logic     vld;
  logic     rdy;

  // payload
  tcb_req_t req;
  tcb_rsp_t rsp;

  // request history, index counts cycles since the handshake
  tcb_req_t req_dly [0:`TCB_HSK_DLY];

  //////////////////////////////////////////////////
  // delayed request line
  //////////////////////////////////////////////////

  // element 0 is the live request
  assign req_dly[0] = req;

  for (genvar i = 1; i <= `TCB_HSK_DLY; i++) begin : g_dly
    if (i == 1) begin : g_hsk
      // capture only accepted requests
      always_ff @(posedge clk) begin
        if (!rst_n) begin
          req_dly[i] <= '0;
        end else if (vld && rdy) begin
          req_dly[i] <= req_dly[i-1];
        end
      end
    end else begin : g_pipe
      // later stages follow the response pipeline
      always_ff @(posedge clk) begin
        if (!rst_n) begin
          req_dly[i] <= '0;
        end else begin
          req_dly[i] <= req_dly[i-1];
        end
      end
    end
  end

  // manager drives handshake and request
  modport man (
    input  clk, rst_n,
    output vld, req,
    input  rdy, rsp, req_dly
  );

  // subordinate answers
  modport sub (
    input  clk, rst_n,
    input  vld, req, req_dly,
    output rdy, rsp
  );

endinterface

`default_nettype wire

/* tcb_lib_logsize2byteena.sv */
// unaligned mode only, lanes wrap inside one word and no access is split; little and big endian only
`timescale 1ns/10ps
`default_nettype none

`include "tcb_defs.svh"

module tcb_lib_logsize2byteena (
  // log-size manager connects here
  tcb_if.sub sub,
  // byte-enable subordinate connects here
  tcb_if.man man
);

  import tcb_pkg::*;

  // short aliases for lane count and offset width
  localparam int unsigned BYT = `TCB_BUS_BYT;
  localparam int unsigned MAX = `TCB_BUS_MAX;

  //////////////////////////////////////////////////
  // lane mapping
  //////////////////////////////////////////////////

  // big endian mapping is its own inverse
  // little endian needs a direction
  // fwd set gives lane of data byte idx, clear gives data byte of lane idx
  function automatic logic [MAX-1:0] lane_sel (
    input logic [MAX-1:0] idx,
    input logic [MAX-1:0] off,
    input logic [MAX-1:0] lst,
    input tcb_ndn_t       ndn,
    input logic           fwd
  );
    if (ndn == TCB_BIG) begin
      lane_sel = lst - idx + off;
    end else if (fwd) begin
      lane_sel = idx + off;
    end else begin
      lane_sel = idx - off;
    end
  endfunction

  //////////////////////////////////////////////////
  // local signals
  //////////////////////////////////////////////////

  // request side, live request
  logic [MAX-1:0] req_off;
  logic [MAX-1:0] req_lst;
  tcb_siz_t       req_siz;
  tcb_ndn_t       req_ndn;

  // response side, request of the transfer being answered
  logic [MAX-1:0] rsp_off;
  logic [MAX-1:0] rsp_lst;
  tcb_siz_t       rsp_siz;
  tcb_ndn_t       rsp_ndn;

  // converted payload
  tcb_ben_t       man_byt;
  tcb_dat_t       man_wdt;
  tcb_dat_t       sub_rdt;
  tcb_req_t       man_req;

  assign req_off = sub.req_dly[0].adr[MAX-1:0];
  assign req_siz = sub.req_dly[0].siz;
  assign req_ndn = sub.req_dly[0].ndn;

  assign rsp_off = sub.req_dly[`TCB_HSK_DLY].adr[MAX-1:0];
  assign rsp_siz = sub.req_dly[`TCB_HSK_DLY].siz;
  assign rsp_ndn = sub.req_dly[`TCB_HSK_DLY].ndn;

  // index of last byte in the access, wraps for oversize
  assign req_lst = MAX'((1 << req_siz) - 1);
  assign rsp_lst = MAX'((1 << rsp_siz) - 1);

  //////////////////////////////////////////////////
  // per-lane multiplexers
  //////////////////////////////////////////////////

  for (genvar i = 0; i < BYT; i++) begin : g_lane
    // data byte position of lane i, little endian view
    logic [MAX-1:0] ben_idx;
    // source byte for write lane i
    logic [MAX-1:0] wr_sel;
    // source lane for read byte i
    logic [MAX-1:0] rd_sel;

    assign ben_idx = MAX'(i) - req_off;

    // lane is live when its byte falls inside the size
    assign man_byt[i] = (int'(ben_idx) < (1 << req_siz));

    assign wr_sel = lane_sel(MAX'(i), req_off, req_lst, req_ndn, 1'b0);
    assign rd_sel = lane_sel(MAX'(i), rsp_off, rsp_lst, rsp_ndn, 1'b1);

    // rotate write data onto lanes
    assign man_wdt[i] = sub.req_dly[0].wdt[wr_sel];

    // rotate read data back to byte order
    assign sub_rdt[i] = man.rsp.rdt[rd_sel];
  end

  //////////////////////////////////////////////////
  // request
  //////////////////////////////////////////////////

  // handshake passes straight through
  assign man.vld = sub.vld;

  // wen, adr, siz and ndn unchanged
  always_comb begin
    man_req     = sub.req_dly[0];
    man_req.byt = man_byt;
    man_req.wdt = man_wdt;
  end

  assign man.req = man_req;

  //////////////////////////////////////////////////
  // response
  //////////////////////////////////////////////////

  // status is not touched
  assign sub.rsp = '{rdt: sub_rdt, sts: man.rsp.sts};

  // only stall comes from the subordinate
  assign sub.rdy = man.rdy;

endmodule

`default_nettype wire

/* tcb_mem.sv */
// byte-enable mode only; one-cycle response, words at or above TCB_MEM_DEPTH answer with an error
`timescale 1ns/10ps
`default_nettype none

`include "tcb_defs.svh"

module tcb_mem (
  // byte-enable manager connects here
  tcb_if.sub sub
);

  import tcb_pkg::*;

  // index width of the implemented words
  localparam int unsigned IDX_W = $clog2(`TCB_MEM_DEPTH);

  //////////////////////////////////////////////////
  // storage and address decode
  //////////////////////////////////////////////////

  // byte storage, one bus word per entry
  tcb_dat_t mem [0:`TCB_MEM_DEPTH-1];

  // word address, offset bits dropped
  logic [`TCB_ADR_WIDTH-`TCB_BUS_MAX-1:0] wrd;
  logic [IDX_W-1:0]                       idx;
  logic                                   in_rng;

  // handshake and response registers
  logic     trn;
  logic     rdy_q;
  tcb_dat_t rdt_q;
  logic     sts_q;

  assign wrd    = sub.req.adr[`TCB_ADR_WIDTH-1:`TCB_BUS_MAX];
  assign idx    = wrd[IDX_W-1:0];
  assign in_rng = (wrd < `TCB_MEM_DEPTH);

  // transfer on vld and rdy together
  assign trn = sub.vld && rdy_q;

  //////////////////////////////////////////////////
  // ready
  //////////////////////////////////////////////////

  // low in reset, then always ready
  always_ff @(posedge sub.clk) begin
    if (!sub.rst_n) begin
      rdy_q <= 1'b0;
    end else begin
      rdy_q <= 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // write
  //////////////////////////////////////////////////

  // only enabled lanes change
  always_ff @(posedge sub.clk) begin
    if (trn && sub.req.wen && in_rng) begin
      for (int unsigned b = 0; b < `TCB_BUS_BYT; b++) begin
        if (sub.req.byt[b]) begin
          mem[idx][b] <= sub.req.wdt[b];
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // read and status
  //////////////////////////////////////////////////

  // full word on read, zero otherwise
  // rdy is low in reset so this also clears there
  always_ff @(posedge sub.clk) begin
    if (trn && !sub.req.wen && in_rng) begin
      rdt_q <= mem[idx];
    end else begin
      rdt_q <= '0;
    end
  end

  // error flag for one cycle after an out-of-range transfer
  always_ff @(posedge sub.clk) begin
    if (!sub.rst_n) begin
      sts_q <= 1'b0;
    end else begin
      sts_q <= trn && !in_rng;
    end
  end

  assign sub.rdy = rdy_q;
  assign sub.rsp = '{rdt: rdt_q, sts: sts_q};

endmodule

`default_nettype wire

/* tcb_top.sv */
// log-size manager ports in front of a byte-enable memory; no response stall, sizes up to 4 bytes
`timescale 1ns/10ps
`default_nettype none

`include "tcb_defs.svh"

module tcb_top (
  // clock and synchronous reset
  input  logic                      clk,
  input  logic                      rst_n,
  // manager handshake
  input  logic                      vld,
  output logic                      rdy,
  // request, log-size form
  input  logic                      wen,
  input  logic [`TCB_ADR_WIDTH-1:0] adr,
  input  tcb_pkg::tcb_siz_t         siz,
  input  tcb_pkg::tcb_ndn_t         ndn,
  input  tcb_pkg::tcb_dat_t         wdt,
  // response, one cycle after handshake
  output tcb_pkg::tcb_dat_t         rdt,
  output logic                      sts
);

  //////////////////////////////////////////////////
  // bus instances
  //////////////////////////////////////////////////

  // log-size side, faces the ports
  tcb_if bus_sub (
    .clk   (clk),
    .rst_n (rst_n)
  );

  // byte-enable side, faces the memory
  tcb_if bus_man (
    .clk   (clk),
    .rst_n (rst_n)
  );

  //////////////////////////////////////////////////
  // port mapping
  //////////////////////////////////////////////////

  assign bus_sub.vld = vld;

  // byt unused in log-size mode
  assign bus_sub.req = '{
    wen: wen,
    adr: adr,
    siz: siz,
    ndn: ndn,
    byt: '0,
    wdt: wdt
  };

  assign rdy = bus_sub.rdy;
  assign rdt = bus_sub.rsp.rdt;
  assign sts = bus_sub.rsp.sts;

  //////////////////////////////////////////////////
  // converter and memory
  //////////////////////////////////////////////////

  tcb_lib_logsize2byteena conv_i (
    .sub (bus_sub),
    .man (bus_man)
  );

  tcb_mem mem_i (
    .sub (bus_man)
  );

endmodule

`default_nettype wire

/* tb_tcb_top.sv */
// model-based test of tcb_top; every word is filled through the bus before stored data is read back
`timescale 1ns/10ps
`default_nettype none

`include "tcb_defs.svh"

module tb_tcb_top;

  import tcb_pkg::*;

  // bytes held by the memory
  localparam int unsigned NBYT = `TCB_MEM_DEPTH * `TCB_BUS_BYT;

  logic                      clk;
  logic                      rst_n;
  logic                      vld;
  logic                      rdy;
  logic                      wen;
  logic [`TCB_ADR_WIDTH-1:0] adr;
  tcb_siz_t                  siz;
  tcb_ndn_t                  ndn;
  tcb_dat_t                  wdt;
  tcb_dat_t                  rdt;
  logic                      sts;

  // reference byte storage, index is the byte address
  tcb_byte_t ref_mem [0:NBYT-1];
  // expected response for the cycle after a handshake
  tcb_dat_t  exp_rdt_q [$];
  logic      exp_sts_q [$];

  logic [31:0] lcg_state;
  int          err_cnt;
  int          chk_cnt;
  int          tst_err;
  string       tst_name;

  tcb_top dut_i (
    .clk   (clk),
    .rst_n (rst_n),
    .vld   (vld),
    .rdy   (rdy),
    .wen   (wen),
    .adr   (adr),
    .siz   (siz),
    .ndn   (ndn),
    .wdt   (wdt),
    .rdt   (rdt),
    .sts   (sts)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////

  // lcg, upper half only since low bits repeat quickly
  function automatic logic [15:0] rand_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[31:16];
  endfunction

  function automatic tcb_dat_t rand_dat();
    return {rand_next(), rand_next()};
  endfunction

  // oor picks an address past the implemented words
  function automatic logic [`TCB_ADR_WIDTH-1:0] rand_adr(input logic oor);
    if (oor) begin
      return `TCB_ADR_WIDTH'(NBYT + rand_next() % ((1 << `TCB_ADR_WIDTH) - NBYT));
    end
    return `TCB_ADR_WIDTH'(rand_next() % NBYT);
  endfunction

  // fill byte mixes all address bits
  function automatic tcb_dat_t fill_word(input logic [`TCB_ADR_WIDTH-1:0] a);
    tcb_dat_t                  d;
    logic [`TCB_ADR_WIDTH-1:0] ba;
    for (int b = 0; b < `TCB_BUS_BYT; b++) begin
      ba   = a + `TCB_ADR_WIDTH'(b);
      d[b] = ba[7:0] ^ ba[15:8] ^ 8'h3c;
    end
    return d;
  endfunction

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////

  // lane of data byte k, modulo-4 wrap inside the word
  function automatic int lane_of(input int k, input logic [`TCB_BUS_MAX-1:0] off,
                                 input tcb_siz_t s, input tcb_ndn_t n);
    if (n == TCB_BIG) begin
      return (int'(off) + (1 << s) + 3 - k) % 4;
    end
    return (int'(off) + k) % 4;
  endfunction

  // updates storage on a write, gives the expected rdt
  function automatic tcb_dat_t model_apply(input logic w, input logic [`TCB_ADR_WIDTH-1:0] a,
                                           input tcb_siz_t s, input tcb_ndn_t n,
                                           input tcb_dat_t d);
    int       base;
    int       ln;
    tcb_dat_t res;
    res  = '0;
    base = int'(a >> `TCB_BUS_MAX) * `TCB_BUS_BYT;
    if (base >= NBYT) begin
      return res;
    end
    for (int k = 0; k < `TCB_BUS_BYT; k++) begin
      ln = lane_of(k, a[`TCB_BUS_MAX-1:0], s, n);
      if (w && k < (1 << s)) begin
        ref_mem[base + ln] = d[k];
      end else if (!w) begin
        res[k] = ref_mem[base + ln];
      end
    end
    return res;
  endfunction

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  task automatic check_dat(input string name, input tcb_dat_t exp, input tcb_dat_t act);
    chk_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("[FAIL] %0t ns %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_sts(input string name, input logic exp, input logic act);
    chk_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("[FAIL] %0t ns %s expected %b got %b", $time, name, exp, act);
    end
  endtask

  task automatic check_rdy(input string name, input logic exp, input logic act);
    chk_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("[FAIL] %0t ns %s expected %b got %b", $time, name, exp, act);
    end
  endtask

  // responses show between edges, so sample on the falling edge
  // a handshake seen here completes on the next rising edge
  always @(negedge clk) begin
    if (exp_rdt_q.size() > 0) begin
      check_dat("rdt", exp_rdt_q.pop_front(), rdt);
      check_sts("sts", exp_sts_q.pop_front(), sts);
    end
    if (vld && rdy === 1'b1) begin
      exp_sts_q.push_back((adr >> `TCB_BUS_MAX) >= `TCB_MEM_DEPTH);
      exp_rdt_q.push_back(model_apply(wen, adr, siz, ndn, wdt));
    end
  end

  //////////////////////////////////////////////////
  // bus driver
  //////////////////////////////////////////////////

  // returns once the request will be taken on the next edge
  task automatic send(input logic w, input logic [`TCB_ADR_WIDTH-1:0] a, input tcb_siz_t s,
                      input tcb_ndn_t n, input tcb_dat_t d);
    int t;
    @(posedge clk);
    vld <= 1'b1;
    wen <= w;
    adr <= a;
    siz <= s;
    ndn <= n;
    wdt <= d;
    t = 0;
    @(negedge clk);
    while (rdy !== 1'b1) begin
      t++;
      if (t > 20) begin
        $display("timeout: rdy stayed low while a request was waiting at %0t ns", $time);
        $display("ERRORS FOUND");
        $finish;
      end
      @(negedge clk);
    end
  endtask

  // drop vld and wait for the last response check
  task automatic drain();
    int t;
    @(posedge clk);
    vld <= 1'b0;
    t = 0;
    @(negedge clk);
    while (exp_rdt_q.size() > 0) begin
      t++;
      if (t > 20) begin
        $display("timeout: expected responses never arrived at %0t ns", $time);
        $display("ERRORS FOUND");
        $finish;
      end
      @(negedge clk);
    end
  endtask

  task automatic begin_test(input string name);
    tst_name = name;
    tst_err  = err_cnt;
  endtask

  task automatic end_test();
    drain();
    $display("test %-10s %s", tst_name, (err_cnt == tst_err) ? "ok" : "failed");
  endtask

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial begin
    logic [`TCB_ADR_WIDTH-1:0] a;
    tcb_siz_t                  s;
    tcb_ndn_t                  n;
    rst_n     = 1'b0;
    vld       = 1'b0;
    wen       = 1'b0;
    adr       = '0;
    siz       = TCB_SIZ_1;
    ndn       = TCB_LITTLE;
    wdt       = '0;
    lcg_state = 32'd38;
    err_cnt   = 0;
    chk_cnt   = 0;

    // reset held for 4 rising edges
    begin_test("reset");
    repeat (3) begin
      @(negedge clk);
      check_rdy("rdy", 1'b0, rdy);
      check_sts("sts", 1'b0, sts);
    end
    @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_rdy("rdy", 1'b0, rdy);
    check_sts("sts", 1'b0, sts);
    @(negedge clk);
    check_rdy("rdy", 1'b1, rdy);
    end_test();

    // fill every word, then aligned little endian pairs
    begin_test("aligned");
    for (int w = 0; w < `TCB_MEM_DEPTH; w++) begin
      a = `TCB_ADR_WIDTH'(w * `TCB_BUS_BYT);
      send(1'b1, a, TCB_SIZ_4, TCB_LITTLE, fill_word(a));
    end
    for (int i = 0; i < 24; i++) begin
      s = tcb_siz_t'(i % 3);
      a = `TCB_ADR_WIDTH'(((rand_next() % NBYT) >> s) << s);
      send(1'b1, a, s, TCB_LITTLE, rand_dat());
      send(1'b0, a, s, TCB_LITTLE, '0);
    end
    end_test();

    // big endian, plus a little endian word read to expose lane order
    begin_test("big");
    for (int i = 0; i < 18; i++) begin
      s = tcb_siz_t'(i % 3);
      a = `TCB_ADR_WIDTH'(((rand_next() % NBYT) >> s) << s);
      send(1'b1, a, s, TCB_BIG, rand_dat());
      send(1'b0, a, s, TCB_BIG, '0);
      send(1'b0, {a[`TCB_ADR_WIDTH-1:`TCB_BUS_MAX], 2'b00}, TCB_SIZ_4, TCB_LITTLE, '0);
    end
    end_test();

    // offset plus size past the word end
    begin_test("wrap");
    for (int e = 0; e < 2; e++) begin
      for (int off = 1; off < `TCB_BUS_BYT; off++) begin
        for (int k = 1; k < 3; k++) begin
          s = tcb_siz_t'(k);
          n = tcb_ndn_t'(e);
          if (off + (1 << k) > `TCB_BUS_BYT) begin
            a = `TCB_ADR_WIDTH'((rand_next() % `TCB_MEM_DEPTH) * `TCB_BUS_BYT + off);
            send(1'b1, a, s, n, rand_dat());
            send(1'b0, a, s, n, '0);
            send(1'b0, {a[`TCB_ADR_WIDTH-1:`TCB_BUS_MAX], 2'b00}, TCB_SIZ_4, TCB_LITTLE, '0);
          end
        end
      end
    end
    end_test();

    // beyond the depth, then a full read-back
    begin_test("range");
    send(1'b1, `TCB_ADR_WIDTH'(NBYT), TCB_SIZ_4, TCB_LITTLE, rand_dat());
    send(1'b0, '1, TCB_SIZ_1, TCB_BIG, '0);
    for (int i = 0; i < 10; i++) begin
      send(1'(rand_next() % 2), rand_adr(1'b1), tcb_siz_t'(rand_next() % 3),
           tcb_ndn_t'(rand_next() % 2), rand_dat());
    end
    for (int w = 0; w < `TCB_MEM_DEPTH; w++) begin
      send(1'b0, `TCB_ADR_WIDTH'(w * `TCB_BUS_BYT), TCB_SIZ_4, TCB_LITTLE, '0);
    end
    end_test();

    // back-to-back mix, about one in 16 out of range
    begin_test("random");
    for (int i = 0; i < 300; i++) begin
      a = rand_adr(rand_next() % 16 == 0);
      send(1'(rand_next() % 2), a, tcb_siz_t'(rand_next() % 3),
           tcb_ndn_t'(rand_next() % 2), rand_dat());
    end
    end_test();

    $display("checks %0d, errors %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
+incdir+.
tcb_pkg.sv
tcb_if.sv
tcb_lib_logsize2byteena.sv
tcb_mem.sv
tcb_top.sv
tb_tcb_top.sv
